//--- core_pkg.sv
package core_pkg;

    // datapath widths
    localparam int data_width     = 32;
    localparam int reg_addr_width = 5;
    localparam int num_regs       = 32;

    // source operands per instruction, also register file read ports
    localparam int num_src = 2;

    // major opcodes
    localparam logic [5:0] op_rtype = 6'h00;
    localparam logic [5:0] op_addi  = 6'h08;
    localparam logic [5:0] op_ori   = 6'h0d;
    localparam logic [5:0] op_lui   = 6'h0f;

    // r-type function codes
    localparam logic [10:0] fn_add = 11'h020;
    localparam logic [10:0] fn_sub = 11'h022;
    localparam logic [10:0] fn_and = 11'h024;
    localparam logic [10:0] fn_or  = 11'h025;
    localparam logic [10:0] fn_xor = 11'h026;
    localparam logic [10:0] fn_slt = 11'h02a;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b
    } alu_op_e;

    // one instruction word, two layouts
    // opcode, rd and rs1 sit at the same bits in both
    typedef union packed {
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rd;
            logic [4:0]  rs1;
            logic [4:0]  rs2;
            logic [10:0] funct;
        } r_fields;
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rd;
            logic [4:0]  rs1;
            logic [15:0] imm;
        } i_fields;
    } instr_word_u;

endpackage

//--- core_top.sv
`timescale 1ns/10ps

module core_top (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                inst_valid,
    input  logic [core_pkg::data_width-1:0]     inst_word,
    input  logic [core_pkg::data_width-1:0]     inst_pc,
    output logic                                wb_valid,
    output logic                                wb_we,
    output logic [core_pkg::reg_addr_width-1:0] wb_reg,
    output logic [core_pkg::data_width-1:0]     wb_data,
    output logic [core_pkg::data_width-1:0]     wb_pc
);
    import core_pkg::*;

    // ID stage
    logic                      id_valid;
    logic [data_width-1:0]     id_pc;
    logic [reg_addr_width-1:0] id_rd;
    logic                      id_we;
    alu_op_e                   id_alu_op;
    logic [data_width-1:0]     id_imm;
    logic                      id_use_imm;

    logic [num_src-1:0][reg_addr_width-1:0] src_addr;
    logic [num_src-1:0][data_width-1:0]     rf_data;
    logic [num_src-1:0][data_width-1:0]     operand;

    // EX stage forwarding source
    logic                      ex_we;
    logic [reg_addr_width-1:0] ex_addr;
    logic [data_width-1:0]     ex_result;

    decode_unit decode_0 (
        .clock      (clock),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst_word  (inst_word),
        .inst_pc    (inst_pc),
        .id_valid   (id_valid),
        .id_pc      (id_pc),
        .id_rd      (id_rd),
        .id_we      (id_we),
        .id_alu_op  (id_alu_op),
        .id_imm     (id_imm),
        .id_use_imm (id_use_imm),
        .src_addr   (src_addr)
    );

    for (genvar i = 0; i < num_src; i++) begin : g_bypass
        operand_bypass bypass (
            .src_addr  (src_addr[i]),
            .rf_data   (rf_data[i]),
            .ex_we     (ex_we),
            .ex_addr   (ex_addr),
            .ex_result (ex_result),
            .wb_we     (wb_we),
            .wb_addr   (wb_reg),
            .wb_data   (wb_data),
            .operand   (operand[i])
        );
    end

    execute_unit execute_0 (
        .clock      (clock),
        .reset      (reset),
        .id_valid   (id_valid),
        .id_pc      (id_pc),
        .id_rd      (id_rd),
        .id_we      (id_we),
        .id_alu_op  (id_alu_op),
        .id_imm     (id_imm),
        .id_use_imm (id_use_imm),
        .operand    (operand),
        .ex_we      (ex_we),
        .ex_addr    (ex_addr),
        .ex_result  (ex_result),
        .wb_valid   (wb_valid),
        .wb_we      (wb_we),
        .wb_reg     (wb_reg),
        .wb_data    (wb_data),
        .wb_pc      (wb_pc)
    );

    // write port fed straight from the WB register
    register_file regfile_0 (
        .clock    (clock),
        .reset    (reset),
        .src_addr (src_addr),
        .we       (wb_we),
        .waddr    (wb_reg),
        .wdata    (wb_data),
        .rf_data  (rf_data)
    );

endmodule

//--- decode_unit.sv
`timescale 1ns/10ps

module decode_unit (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic                                   inst_valid,
    input  logic [core_pkg::data_width-1:0]        inst_word,
    input  logic [core_pkg::data_width-1:0]        inst_pc,
    output logic                                   id_valid,
    output logic [core_pkg::data_width-1:0]        id_pc,
    output logic [core_pkg::reg_addr_width-1:0]    id_rd,
    output logic                                   id_we,
    output core_pkg::alu_op_e                      id_alu_op,
    output logic [core_pkg::data_width-1:0]        id_imm,
    output logic                                   id_use_imm,
    output logic [core_pkg::num_src-1:0][core_pkg::reg_addr_width-1:0] src_addr
);
    import core_pkg::*;

    instr_word_u                word_q;
    logic [reg_addr_width-1:0]  rs1_sel;
    logic [reg_addr_width-1:0]  rs2_sel;

    always_ff @(posedge clock) begin
        if (reset) begin
            id_valid <= 1'b0;
        end else begin
            id_valid <= inst_valid;
        end
    end

    always_ff @(posedge clock) begin
        word_q <= inst_word;
        id_pc  <= inst_pc;
    end

    always_comb begin
        id_we      = 1'b0;
        id_alu_op  = alu_add;
        id_imm     = '0;
        id_use_imm = 1'b0;
        rs1_sel    = word_q.r_fields.rs1;
        rs2_sel    = word_q.r_fields.rs2;
        case (word_q.r_fields.opcode)
            op_rtype: begin
                id_we = 1'b1;
                case (word_q.r_fields.funct)
                    fn_add:  id_alu_op = alu_add;
                    fn_sub:  id_alu_op = alu_sub;
                    fn_and:  id_alu_op = alu_and;
                    fn_or:   id_alu_op = alu_or;
                    fn_xor:  id_alu_op = alu_xor;
                    fn_slt:  id_alu_op = alu_slt;
                    // unknown funct retires as a no-op
                    default: id_we = 1'b0;
                endcase
            end
            op_addi: begin
                id_we      = 1'b1;
                id_use_imm = 1'b1;
                id_imm     = {{16{word_q.i_fields.imm[15]}}, word_q.i_fields.imm};
            end
            op_ori: begin
                id_we      = 1'b1;
                id_use_imm = 1'b1;
                id_alu_op  = alu_or;
                id_imm     = {16'h0000, word_q.i_fields.imm};
            end
            op_lui: begin
                id_we      = 1'b1;
                id_use_imm = 1'b1;
                id_alu_op  = alu_pass_b;
                id_imm     = {word_q.i_fields.imm, 16'h0000};
                rs1_sel    = '0;
            end
            default: begin
                id_we = 1'b0;
            end
        endcase
        // immediate forms have no second source
        if (id_use_imm) begin
            rs2_sel = '0;
        end
        // r0 is never a write target
        if (word_q.r_fields.rd == '0) begin
            id_we = 1'b0;
        end
    end

    assign id_rd       = word_q.i_fields.rd;
    assign src_addr[0] = rs1_sel;
    assign src_addr[1] = rs2_sel;

endmodule

//--- execute_unit.sv
`timescale 1ns/10ps

module execute_unit (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                id_valid,
    input  logic [core_pkg::data_width-1:0]     id_pc,
    input  logic [core_pkg::reg_addr_width-1:0] id_rd,
    input  logic                                id_we,
    input  core_pkg::alu_op_e                   id_alu_op,
    input  logic [core_pkg::data_width-1:0]     id_imm,
    input  logic                                id_use_imm,
    input  logic [core_pkg::num_src-1:0][core_pkg::data_width-1:0] operand,
    output logic                                ex_we,
    output logic [core_pkg::reg_addr_width-1:0] ex_addr,
    output logic [core_pkg::data_width-1:0]     ex_result,
    output logic                                wb_valid,
    output logic                                wb_we,
    output logic [core_pkg::reg_addr_width-1:0] wb_reg,
    output logic [core_pkg::data_width-1:0]     wb_data,
    output logic [core_pkg::data_width-1:0]     wb_pc
);
    import core_pkg::*;

    logic                  ex_valid;
    logic [data_width-1:0] ex_pc;
    alu_op_e               ex_alu_op;
    logic [data_width-1:0] ex_a;
    logic [data_width-1:0] ex_b;

    // EX register, write enable only counts for a valid slot
    always_ff @(posedge clock) begin
        if (reset) begin
            ex_valid <= 1'b0;
            ex_we    <= 1'b0;
        end else begin
            ex_valid <= id_valid;
            ex_we    <= id_valid & id_we;
        end
    end

    always_ff @(posedge clock) begin
        ex_pc     <= id_pc;
        ex_addr   <= id_rd;
        ex_alu_op <= id_alu_op;
        ex_a      <= operand[0];
        ex_b      <= id_use_imm ? id_imm : operand[1];
    end

    always_comb begin
        case (ex_alu_op)
            alu_add: ex_result = ex_a + ex_b;
            alu_sub: ex_result = ex_a - ex_b;
            alu_and: ex_result = ex_a & ex_b;
            alu_or:  ex_result = ex_a | ex_b;
            alu_xor: ex_result = ex_a ^ ex_b;
            // signed compare
            alu_slt: ex_result = {{(data_width-1){1'b0}}, $signed(ex_a) < $signed(ex_b)};
            default: ex_result = ex_b;
        endcase
    end

    // WB register, wb_we is never high without wb_valid
    always_ff @(posedge clock) begin
        if (reset) begin
            wb_valid <= 1'b0;
            wb_we    <= 1'b0;
        end else begin
            wb_valid <= ex_valid;
            wb_we    <= ex_we;
        end
    end

    always_ff @(posedge clock) begin
        wb_reg  <= ex_addr;
        wb_data <= ex_result;
        wb_pc   <= ex_pc;
    end

endmodule

//--- filelist.f
core_pkg.sv
decode_unit.sv
operand_bypass.sv
register_file.sv
execute_unit.sv
core_top.sv
tb_clock_gen.sv
tb_core.sv

//--- operand_bypass.sv
`timescale 1ns/10ps

module operand_bypass (
    input  logic [core_pkg::reg_addr_width-1:0] src_addr,
    input  logic [core_pkg::data_width-1:0]     rf_data,
    input  logic                                ex_we,
    input  logic [core_pkg::reg_addr_width-1:0] ex_addr,
    input  logic [core_pkg::data_width-1:0]     ex_result,
    input  logic                                wb_we,
    input  logic [core_pkg::reg_addr_width-1:0] wb_addr,
    input  logic [core_pkg::data_width-1:0]     wb_data,
    output logic [core_pkg::data_width-1:0]     operand
);

    logic ex_hit;
    logic wb_hit;

    // r0 needs no check, decode never enables a write to it
    assign ex_hit = ex_we && (ex_addr == src_addr);
    assign wb_hit = wb_we && (wb_addr == src_addr);

    // youngest producer wins
    always_comb begin
        if (ex_hit) begin
            operand = ex_result;
        end else if (wb_hit) begin
            operand = wb_data;
        end else begin
            operand = rf_data;
        end
    end

endmodule

//--- register_file.sv
`timescale 1ns/10ps

module register_file (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic [core_pkg::num_src-1:0][core_pkg::reg_addr_width-1:0] src_addr,
    input  logic                                   we,
    input  logic [core_pkg::reg_addr_width-1:0]    waddr,
    input  logic [core_pkg::data_width-1:0]        wdata,
    output logic [core_pkg::num_src-1:0][core_pkg::data_width-1:0]     rf_data
);
    import core_pkg::*;

    logic [data_width-1:0] regs [num_regs];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int r = 0; r < num_regs; r++) begin
                regs[r] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // read ports, r0 hardwired to zero
    always_comb begin
        for (int p = 0; p < num_src; p++) begin
            if (src_addr[p] == '0) begin
                rf_data[p] = '0;
            end else begin
                rf_data[p] = regs[src_addr[p]];
            end
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# compile and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_core -f filelist.f -o tb_core_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_core_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation completed successfully"; then
    exit 0
fi
exit 1

//--- tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clock
);

    // 100 ns period
    initial begin
        clock = 1'b0;
        forever begin
            #50 clock = ~clock;
        end
    end

endmodule

//--- tb_core.sv
`timescale 1ns/10ps

module tb_core;
    import core_pkg::*;

    logic        clock;
    logic        reset;
    logic        inst_valid;
    logic [31:0] inst_word;
    logic [31:0] inst_pc;
    logic        wb_valid;
    logic        wb_we;
    logic [4:0]  wb_reg;
    logic [31:0] wb_data;
    logic [31:0] wb_pc;

    int          assert_errors = 0;
    int          check_errors = 0;
    int          other_errors = 0;
    int          cycle = 0;
    int          retired = 0;
    logic [31:0] lcg_state;
    logic [31:0] pc_next;
    logic [31:0] shadow [32];
    logic [2:0]  strobe_hist = '0;

    // expected retirements in program order
    logic [31:0] exp_pc_q [$];
    logic        exp_we_q [$];
    logic [4:0]  exp_rd_q [$];
    logic [31:0] exp_data_q [$];
    int          exp_cycle_q [$];

    tb_clock_gen clock_gen (.clock(clock));

    core_top uut (
        .clock      (clock),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst_word  (inst_word),
        .inst_pc    (inst_pc),
        .wb_valid   (wb_valid),
        .wb_we      (wb_we),
        .wb_reg     (wb_reg),
        .wb_data    (wb_data),
        .wb_pc      (wb_pc)
    );

    always @(posedge clock) begin
        cycle <= cycle + 1;
    end

    // three-deep history of the input strobe
    always @(posedge clock) begin
        strobe_hist <= {strobe_hist[1:0], inst_valid};
    end

    // every strobe retires exactly three cycles later
    assert property (@(posedge clock) disable iff (reset) wb_valid == strobe_hist[2])
        else begin
            assert_errors++;
            $display("Mismatch at %0t: wb_valid expected %b got %b",
                     $time, $sampled(strobe_hist[2]), $sampled(wb_valid));
        end

    assert property (@(posedge clock) disable iff (reset) wb_we |-> wb_valid)
        else begin
            assert_errors++;
            $display("wb_we was high at %0t while wb_valid was low", $time);
        end

    // compare each retirement with the oldest unchecked entry
    always @(negedge clock) begin
        if (!reset && wb_valid) begin
            if (retired >= exp_pc_q.size()) begin
                check_errors++;
                $display("retirement at %0t with no instruction outstanding", $time);
            end else begin
                assert (cycle == exp_cycle_q[retired] + 3) else begin
                    check_errors++;
                    $display("Mismatch at %0t: retire cycle expected %0d got %0d",
                             $time, exp_cycle_q[retired] + 3, cycle);
                end
                assert (wb_pc == exp_pc_q[retired]) else begin
                    check_errors++;
                    $display("Mismatch at %0t: wb_pc expected %h got %h",
                             $time, exp_pc_q[retired], wb_pc);
                end
                assert (wb_we == exp_we_q[retired]) else begin
                    check_errors++;
                    $display("Mismatch at %0t: wb_we expected %b got %b",
                             $time, exp_we_q[retired], wb_we);
                end
                if (exp_we_q[retired]) begin
                    assert (wb_reg == exp_rd_q[retired]) else begin
                        check_errors++;
                        $display("Mismatch at %0t: wb_reg expected %0d got %0d",
                                 $time, exp_rd_q[retired], wb_reg);
                    end
                    assert (wb_data == exp_data_q[retired]) else begin
                        check_errors++;
                        $display("Mismatch at %0t: wb_data expected %h got %h",
                                 $time, exp_data_q[retired], wb_data);
                    end
                end
                retired++;
            end
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [31:0] r_inst(input logic [10:0] funct, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2);
        return {op_rtype, rd, rs1, rs2, funct};
    endfunction

    function automatic logic [31:0] i_inst(input logic [5:0] op, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [15:0] imm);
        return {op, rd, rs1, imm};
    endfunction

    // reference model in plain sequential order
    function automatic void model_issue(input logic [31:0] word, input logic [31:0] pc);
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [15:0] imm;
        logic [31:0] res;
        logic        we;
        rd  = word[25:21];
        a   = shadow[word[20:16]];
        b   = shadow[word[15:11]];
        imm = word[15:0];
        we  = 1'b1;
        res = '0;
        case (word[31:26])
            op_rtype: begin
                case (word[10:0])
                    fn_add:  res = a + b;
                    fn_sub:  res = a - b;
                    fn_and:  res = a & b;
                    fn_or:   res = a | b;
                    fn_xor:  res = a ^ b;
                    fn_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: we = 1'b0;
                endcase
            end
            op_addi: res = a + {{16{imm[15]}}, imm};
            op_ori:  res = a | {16'h0000, imm};
            op_lui:  res = {imm, 16'h0000};
            default: we = 1'b0;
        endcase
        if (rd == 5'd0) begin
            we = 1'b0;
        end
        if (we) begin
            shadow[rd] = res;
        end
        exp_pc_q.push_back(pc);
        exp_we_q.push_back(we);
        exp_rd_q.push_back(rd);
        exp_data_q.push_back(res);
        exp_cycle_q.push_back(cycle);
    endfunction

    // small register range so random code has plenty of dependencies
    function automatic logic [31:0] random_inst();
        logic [31:0] r;
        logic [31:0] s;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] word;
        r   = lcg_next();
        s   = lcg_next();
        rd  = {2'b00, r[18:16]};
        rs1 = {2'b00, r[21:19]};
        rs2 = {2'b00, r[24:22]};
        case (r[31:28])
            4'd0, 4'd1: word = r_inst(fn_add, rd, rs1, rs2);
            4'd2:       word = r_inst(fn_sub, rd, rs1, rs2);
            4'd3:       word = r_inst(fn_and, rd, rs1, rs2);
            4'd4:       word = r_inst(fn_or, rd, rs1, rs2);
            4'd5:       word = r_inst(fn_xor, rd, rs1, rs2);
            4'd6, 4'd7: word = r_inst(fn_slt, rd, rs1, rs2);
            4'd10:      word = i_inst(op_ori, rd, rs1, s[31:16]);
            4'd11:      word = i_inst(op_lui, rd, rs1, s[31:16]);
            4'd12:      word = r_inst(11'h3ff, rd, rs1, rs2);
            4'd13:      word = {6'h3f, s[25:0]};
            default:    word = i_inst(op_addi, rd, rs1, s[31:16]);
        endcase
        return word;
    endfunction

    task automatic issue(input logic [31:0] word);
        inst_valid = 1'b1;
        inst_word  = word;
        inst_pc    = pc_next;
        model_issue(word, pc_next);
        pc_next = pc_next + 32'd4;
        @(negedge clock);
    endtask

    task automatic bubble();
        inst_valid = 1'b0;
        @(negedge clock);
    endtask

    initial begin
        logic drained;
        int   waited;
        int   total;
        reset      = 1'b1;
        inst_valid = 1'b0;
        inst_word  = '0;
        inst_pc    = '0;
        lcg_state  = 32'd81;
        pc_next    = 32'h0000_1000;
        for (int r = 0; r < 32; r++) begin
            shadow[r] = '0;
        end
        repeat (10) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        repeat (5) bubble();

        issue(i_inst(op_addi, 5'd1, 5'd0, 16'hfffb));
        issue(i_inst(op_addi, 5'd2, 5'd0, 16'h0007));
        issue(i_inst(op_ori, 5'd3, 5'd0, 16'h8001));
        issue(i_inst(op_lui, 5'd4, 5'd0, 16'habcd));
        repeat (3) bubble();
        issue(r_inst(fn_add, 5'd5, 5'd1, 5'd2));
        issue(r_inst(fn_sub, 5'd6, 5'd2, 5'd1));
        issue(r_inst(fn_and, 5'd7, 5'd1, 5'd3));
        issue(r_inst(fn_or, 5'd8, 5'd3, 5'd4));
        issue(r_inst(fn_xor, 5'd9, 5'd1, 5'd3));
        issue(r_inst(fn_slt, 5'd10, 5'd1, 5'd2));
        issue(r_inst(fn_slt, 5'd11, 5'd2, 5'd1));
        repeat (3) bubble();

        // distance one chain
        issue(i_inst(op_addi, 5'd1, 5'd1, 16'h0001));
        issue(i_inst(op_addi, 5'd1, 5'd1, 16'h0001));
        issue(r_inst(fn_add, 5'd2, 5'd1, 5'd1));
        // distance two, then three through the register file
        issue(i_inst(op_addi, 5'd3, 5'd0, 16'h000a));
        issue(i_inst(op_addi, 5'd20, 5'd0, 16'h0001));
        issue(r_inst(fn_add, 5'd4, 5'd3, 5'd0));
        issue(r_inst(fn_sub, 5'd5, 5'd0, 5'd3));
        issue(i_inst(op_addi, 5'd6, 5'd0, 16'h0021));
        repeat (2) bubble();
        issue(r_inst(fn_add, 5'd7, 5'd6, 5'd6));
        // younger producer wins
        issue(i_inst(op_addi, 5'd8, 5'd0, 16'h0001));
        issue(i_inst(op_addi, 5'd8, 5'd0, 16'h0002));
        issue(r_inst(fn_add, 5'd9, 5'd8, 5'd8));
        // r0 writes and unknown encodings
        issue(i_inst(op_addi, 5'd0, 5'd0, 16'h0055));
        issue(r_inst(fn_add, 5'd10, 5'd0, 5'd0));
        issue({6'h3f, 5'd11, 5'd1, 16'h0000});
        issue(r_inst(11'h3ff, 5'd12, 5'd1, 5'd2));
        issue(r_inst(fn_or, 5'd13, 5'd11, 5'd12));

        for (int n = 0; n < 300; n++) begin
            issue(random_inst());
        end

        bubble();
        waited = 0;
        while (retired < exp_pc_q.size() && waited < 20) begin
            @(posedge clock);
            waited++;
        end
        drained = (retired >= exp_pc_q.size());
        @(negedge clock);
        if (!drained) begin
            other_errors++;
            $display("timed out waiting for %0d outstanding retirements",
                     exp_pc_q.size() - retired);
        end
        total = assert_errors + check_errors + other_errors;
        $display("errors: %0d assertion, %0d check, %0d other",
                 assert_errors, check_errors, other_errors);
        if (total == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
